/* design/aluPkg.sv */
package aluPkg;

    ////////////////////
    // Word types
    ////////////////////

    // Operands, results and bus data
    typedef logic [31:0] word_t;
    // Raw MIPS instruction word
    typedef logic [31:0] instr_t;
    // Shift amount field
    typedef logic [4:0]  shamt_t;
    // ALU operation select
    typedef logic [4:0]  aluCtrl_t;
    // Wishbone word address
    typedef logic [2:0]  regAddr_t;

    ////////////////////
    // ALU control codes
    ////////////////////

    // Logical group
    localparam aluCtrl_t AND_CONTROL  = 5'd0;
    localparam aluCtrl_t OR_CONTROL   = 5'd1;
    localparam aluCtrl_t XOR_CONTROL  = 5'd2;
    localparam aluCtrl_t NOR_CONTROL  = 5'd3;
    localparam aluCtrl_t LUI_CONTROL  = 5'd4;
    // Shifts by sa field
    localparam aluCtrl_t SLL_CONTROL  = 5'd5;
    localparam aluCtrl_t SRL_CONTROL  = 5'd6;
    localparam aluCtrl_t SRA_CONTROL  = 5'd7;
    // Shifts by low bits of A
    localparam aluCtrl_t SLLV_CONTROL = 5'd8;
    localparam aluCtrl_t SRLV_CONTROL = 5'd9;
    localparam aluCtrl_t SRAV_CONTROL = 5'd10;
    // Trapping arithmetic
    localparam aluCtrl_t ADD_CONTROL  = 5'd11;
    localparam aluCtrl_t SUB_CONTROL  = 5'd12;
    // Wrapping arithmetic
    localparam aluCtrl_t ADDU_CONTROL = 5'd13;
    localparam aluCtrl_t SUBU_CONTROL = 5'd14;
    // Compares
    localparam aluCtrl_t SLT_CONTROL  = 5'd15;
    localparam aluCtrl_t SLTU_CONTROL = 5'd16;

    ////////////////////
    // MIPS opcodes
    ////////////////////

    // R-type instructions select by funct
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0A;
    localparam logic [5:0] OP_SLTIU   = 6'h0B;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;

    // Funct codes under SPECIAL
    localparam logic [5:0] FUNCT_SLL  = 6'h00;
    localparam logic [5:0] FUNCT_SRL  = 6'h02;
    localparam logic [5:0] FUNCT_SRA  = 6'h03;
    localparam logic [5:0] FUNCT_SLLV = 6'h04;
    localparam logic [5:0] FUNCT_SRLV = 6'h06;
    localparam logic [5:0] FUNCT_SRAV = 6'h07;
    localparam logic [5:0] FUNCT_ADD  = 6'h20;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUB  = 6'h22;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_NOR  = 6'h27;
    localparam logic [5:0] FUNCT_SLT  = 6'h2A;
    localparam logic [5:0] FUNCT_SLTU = 6'h2B;

    ////////////////////
    // Register map
    ////////////////////

    localparam regAddr_t OPA_ADDR    = 3'd0;
    localparam regAddr_t OPB_ADDR    = 3'd1;
    // Writing here starts an evaluation
    localparam regAddr_t INSTR_ADDR  = 3'd2;
    // Read only
    localparam regAddr_t RESULT_ADDR = 3'd3;
    localparam regAddr_t STATUS_ADDR = 3'd4;

    // Status register bits
    localparam int OVERFLOW_BIT = 0;
    localparam int RESERVED_BIT = 1;

endpackage

/* design/aluCmdIf.sv */
`timescale 1ns/1ps

interface aluCmdIf import aluPkg::*; ();

    // Register block outputs
    word_t  opA;
    word_t  opB;
    instr_t instr;

    // Decoder flags an unsupported instruction
    logic   aReserved;

    // ALU outputs
    word_t  result;
    logic   overflow;

    // Register side
    modport regs (
        output opA, opB, instr,
        input  result, overflow, aReserved
    );

    // Instruction decoder
    modport decode (
        input  instr, opA, opB,
        output aReserved
    );

    // Execute side
    modport alu (
        output result, overflow
    );

endinterface

/* design/wbAluRegs.sv */
`timescale 1ns/1ps

module wbAluRegs import aluPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     wbCyc,
    input  logic     wbStb,
    input  logic     wbWe,
    input  regAddr_t wbAdr,
    input  word_t    wbDatW,
    output word_t    wbDatR,
    output logic     wbAck,
    aluCmdIf.regs    cmd
);

    // Host visible registers
    word_t  opAReg;
    word_t  opBReg;
    instr_t instrReg;
    word_t  resultReg;
    logic [RESERVED_BIT:0] statusReg;

    // Instruction written, commit due next edge
    logic   pending;

    // New request this cycle
    logic   accept;
    // Read mux output
    word_t  readData;

    ////////////////////
    // Bus handshake
    ////////////////////

    // Ack low gates acceptance so a held request is served once per ack
    assign accept = wbCyc & wbStb & ~wbAck;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wbAck <= 1'b0;
        end
        else
        begin
            wbAck <= accept;
        end
    end

    // Register readback selection
    always_comb
    begin
        case (wbAdr)
            OPA_ADDR:    readData = opAReg;
            OPB_ADDR:    readData = opBReg;
            INSTR_ADDR:  readData = instrReg;
            RESULT_ADDR: readData = resultReg;
            STATUS_ADDR: readData = {{(32 - RESERVED_BIT - 1){1'b0}}, statusReg};
            // Unmapped reads return zero
            default:     readData = '0;
        endcase
    end

    // Read data captured with the edge that raises ack
    always_ff @(posedge clk)
    begin
        if (accept && !wbWe)
        begin
            wbDatR <= readData;
        end
    end

    ////////////////////
    // Register writes
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            opAReg   <= '0;
            opBReg   <= '0;
            instrReg <= '0;
            pending  <= 1'b0;
        end
        else
        begin
            // Pending lasts exactly one cycle
            pending <= 1'b0;
            if (accept && wbWe)
            begin
                case (wbAdr)
                    OPA_ADDR: opAReg <= wbDatW;
                    OPB_ADDR: opBReg <= wbDatW;
                    INSTR_ADDR:
                    begin
                        instrReg <= wbDatW;
                        pending  <= 1'b1;
                    end
                    // Result and status writes are dropped
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // Commit
    ////////////////////

    // Trap rules keep the old result and flag the cause
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            resultReg <= '0;
            statusReg <= '0;
        end
        else if (pending)
        begin
            if (cmd.aReserved)
            begin
                statusReg[RESERVED_BIT] <= 1'b1;
                statusReg[OVERFLOW_BIT] <= 1'b0;
            end
            else if (cmd.overflow)
            begin
                statusReg[OVERFLOW_BIT] <= 1'b1;
                statusReg[RESERVED_BIT] <= 1'b0;
            end
            else
            begin
                resultReg <= cmd.result;
                statusReg <= '0;
            end
        end
    end

    // Operands and instruction feed decode
    assign cmd.opA   = opAReg;
    assign cmd.opB   = opBReg;
    assign cmd.instr = instrReg;

endmodule

/* design/mipsAluDecode.sv */
`timescale 1ns/1ps

module mipsAluDecode import aluPkg::*; (
    aluCmdIf.decode  cmd,
    output aluCtrl_t aluControl,
    output word_t    a,
    output word_t    b,
    output shamt_t   sa
);

    // Instruction fields
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    word_t       immSext;
    word_t       immZext;

    assign opcode  = cmd.instr[31:26];
    assign funct   = cmd.instr[5:0];
    assign imm     = cmd.instr[15:0];
    assign immSext = {{16{imm[15]}}, imm};
    assign immZext = {16'h0000, imm};

    // rs always drives A
    assign a  = cmd.opA;
    // Shift amount field, only meaningful for R-type
    assign sa = cmd.instr[10:6];

    always_comb
    begin
        // Defaults for an R-type with a known funct
        aluControl    = AND_CONTROL;
        b             = cmd.opB;
        cmd.aReserved = 1'b0;

        case (opcode)
            OP_SPECIAL:
            begin
                case (funct)
                    FUNCT_SLL:  aluControl = SLL_CONTROL;
                    FUNCT_SRL:  aluControl = SRL_CONTROL;
                    FUNCT_SRA:  aluControl = SRA_CONTROL;
                    FUNCT_SLLV: aluControl = SLLV_CONTROL;
                    FUNCT_SRLV: aluControl = SRLV_CONTROL;
                    FUNCT_SRAV: aluControl = SRAV_CONTROL;
                    FUNCT_ADD:  aluControl = ADD_CONTROL;
                    FUNCT_ADDU: aluControl = ADDU_CONTROL;
                    FUNCT_SUB:  aluControl = SUB_CONTROL;
                    FUNCT_SUBU: aluControl = SUBU_CONTROL;
                    FUNCT_AND:  aluControl = AND_CONTROL;
                    FUNCT_OR:   aluControl = OR_CONTROL;
                    FUNCT_XOR:  aluControl = XOR_CONTROL;
                    FUNCT_NOR:  aluControl = NOR_CONTROL;
                    FUNCT_SLT:  aluControl = SLT_CONTROL;
                    FUNCT_SLTU: aluControl = SLTU_CONTROL;
                    default:    cmd.aReserved = 1'b1;
                endcase
            end
            // ADDI keeps the overflow trap
            OP_ADDI:
            begin
                aluControl = ADD_CONTROL;
                b          = immSext;
            end
            OP_ADDIU:
            begin
                aluControl = ADDU_CONTROL;
                b          = immSext;
            end
            OP_SLTI:
            begin
                aluControl = SLT_CONTROL;
                b          = immSext;
            end
            // Sign extended, but compared unsigned
            OP_SLTIU:
            begin
                aluControl = SLTU_CONTROL;
                b          = immSext;
            end
            // Logical immediates zero extend
            OP_ANDI:
            begin
                aluControl = AND_CONTROL;
                b          = immZext;
            end
            OP_ORI:
            begin
                aluControl = OR_CONTROL;
                b          = immZext;
            end
            OP_XORI:
            begin
                aluControl = XOR_CONTROL;
                b          = immZext;
            end
            // ALU moves the low half up
            OP_LUI:
            begin
                aluControl = LUI_CONTROL;
                b          = immZext;
            end
            default: cmd.aReserved = 1'b1;
        endcase
    end

endmodule

/* design/mipsAlu.sv */
`timescale 1ns/1ps

module mipsAlu import aluPkg::*; (
    input  aluCtrl_t aluControl,
    input  word_t    a,
    input  word_t    b,
    input  shamt_t   sa,
    aluCmdIf.alu     cmd
);

    // 33-bit sign extended sum and difference
    logic [32:0] sumExt;
    logic [32:0] diffExt;
    // Only ADD and SUB carry a trap result
    logic [32:0] trapExt;
    word_t       aluResult;

    // Variable shift amount from rs
    shamt_t      varSa;

    assign sumExt  = {a[31], a} + {b[31], b};
    assign diffExt = {a[31], a} - {b[31], b};
    assign varSa   = a[4:0];

    always_comb
    begin
        case (aluControl)
            ADD_CONTROL: trapExt = sumExt;
            SUB_CONTROL: trapExt = diffExt;
            default:     trapExt = '0;
        endcase
    end

    // Top two bits differ on signed overflow
    assign cmd.overflow = trapExt[32] ^ trapExt[31];

    always_comb
    begin
        case (aluControl)
            AND_CONTROL:  aluResult = a & b;
            OR_CONTROL:   aluResult = a | b;
            XOR_CONTROL:  aluResult = a ^ b;
            NOR_CONTROL:  aluResult = ~(a | b);
            LUI_CONTROL:  aluResult = {b[15:0], 16'h0000};
            SLL_CONTROL:  aluResult = b << sa;
            SRL_CONTROL:  aluResult = b >> sa;
            // Arithmetic shifts fill with the sign of B
            SRA_CONTROL:  aluResult = $signed(b) >>> sa;
            SLLV_CONTROL: aluResult = b << varSa;
            SRLV_CONTROL: aluResult = b >> varSa;
            SRAV_CONTROL: aluResult = $signed(b) >>> varSa;
            ADD_CONTROL,
            SUB_CONTROL:  aluResult = trapExt[31:0];
            ADDU_CONTROL: aluResult = a + b;
            SUBU_CONTROL: aluResult = a - b;
            SLT_CONTROL:  aluResult = {31'd0, $signed(a) < $signed(b)};
            SLTU_CONTROL: aluResult = {31'd0, a < b};
            // Unknown codes
            default:      aluResult = '0;
        endcase
    end

    assign cmd.result = aluResult;

endmodule

/* design/aluTop.sv */
`timescale 1ns/1ps

module aluTop import aluPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     wbCyc,
    input  logic     wbStb,
    input  logic     wbWe,
    input  regAddr_t wbAdr,
    input  word_t    wbDatW,
    output word_t    wbDatR,
    output logic     wbAck
);

    // Register block to decode and ALU
    aluCmdIf cmdIf ();

    // Decoder to ALU control and operands
    aluCtrl_t aluControl;
    word_t    a;
    word_t    b;
    shamt_t   sa;

    ////////////////////
    // Bus slave
    ////////////////////

    wbAluRegs wbAluRegs_i (
        .clk    (clk),
        .reset  (reset),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .cmd    (cmdIf.regs)
    );

    ////////////////////
    // Execute path
    ////////////////////

    mipsAluDecode mipsAluDecode_i (
        .cmd        (cmdIf.decode),
        .aluControl (aluControl),
        .a          (a),
        .b          (b),
        .sa         (sa)
    );

    mipsAlu mipsAlu_i (
        .aluControl (aluControl),
        .a          (a),
        .b          (b),
        .sa         (sa),
        .cmd        (cmdIf.alu)
    );

endmodule

/* verif/tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen (
    output logic clk,
    output logic reset
);

    // Half of the 4 ns period
    localparam int HALF_PERIOD = 2;
    // Reset length in clock cycles
    localparam int RESET_CYCLES = 10;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // Released just after an edge, like the bus stimulus
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* verif/aluTopTb.sv */
`timescale 1ns/1ps

module aluTopTb import aluPkg::*; ();

    // About twice the length of the directed sequence
    localparam int TIMEOUT_CYCLES = 2000;

    logic     clk;
    logic     reset;
    logic     wbCyc;
    logic     wbStb;
    logic     wbWe;
    regAddr_t wbAdr;
    word_t    wbDatW;
    word_t    wbDatR;
    logic     wbAck;

    int    errorCount = 0;
    int    checkCount = 0;
    int    cycleCount = 0;

    // Expected register contents after each commit
    word_t                 expResult;
    logic [RESERVED_BIT:0] expStatus;
    // Operand values last written to the DUT
    word_t                 shadowA;
    word_t                 shadowB;

    tbClockGen clockGen_i (
        .clk   (clk),
        .reset (reset)
    );

    aluTop aluTop_i (
        .clk    (clk),
        .reset  (reset),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    // Watchdog on the whole run
    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run passed %0d cycles without finishing", cycleCount);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////
    // Bus driver
    ////////////////////

    // Sample just after the edge where ack and read data are stable
    task automatic waitAck();
        @(posedge clk);
        #1;
        // Ack due on the first edge after the request
        checkAck(wbAck, 1'b1, "one cycle after the request");
        while (!wbAck)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wbWrite(input regAddr_t adr, input word_t data);
        @(posedge clk);
        #1;
        // Previous ack lasts a single cycle
        checkAck(wbAck, 1'b0, "before a new request");
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = 1'b1;
        wbAdr  = adr;
        wbDatW = data;
        waitAck();
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
    endtask

    task automatic wbRead(input regAddr_t adr, output word_t data);
        @(posedge clk);
        #1;
        checkAck(wbAck, 1'b0, "before a new request");
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = adr;
        waitAck();
        data  = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkStatus(input logic [RESERVED_BIT:0] got,
                               input logic [RESERVED_BIT:0] exp, input string what);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("Error at %0t: status %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkAddr(input regAddr_t adr, input word_t got, input word_t exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("Error at %0t: readback of address %0d is %h, expected %h",
                     $time, adr, got, exp);
        end
    endtask

    task automatic checkAck(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("Error at %0t: ack %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Shift in copies of the sign bit from the top
    function automatic word_t sraRef(input word_t val, input shamt_t amt);
        word_t fill;
        fill = val[31] ? ~(32'hFFFF_FFFF >> amt) : 32'h0000_0000;
        return (val >> amt) | fill;
    endfunction

    task automatic predictExec(input instr_t ins, input word_t opA, input word_t opB,
                               output word_t res, output logic ovf, output logic rsv);
        logic [5:0] op;
        logic [5:0] fn;
        shamt_t     sh;
        word_t      se;
        word_t      ze;
        longint     sa64;
        longint     sb64;
        longint     sum;
        op   = ins[31:26];
        fn   = ins[5:0];
        sh   = ins[10:6];
        se   = {{16{ins[15]}}, ins[15:0]};
        ze   = {16'h0000, ins[15:0]};
        res  = '0;
        ovf  = 1'b0;
        rsv  = 1'b0;
        sa64 = longint'($signed(opA));
        // Immediate forms use the sign extended value as rt
        sb64 = (op == OP_SPECIAL) ? longint'($signed(opB)) : longint'($signed(se));
        sum  = 0;
        if (op == OP_SPECIAL)
        begin
            case (fn)
                FUNCT_SLL:  res = opB << sh;
                FUNCT_SRL:  res = opB >> sh;
                FUNCT_SRA:  res = sraRef(opB, sh);
                FUNCT_SLLV: res = opB << opA[4:0];
                FUNCT_SRLV: res = opB >> opA[4:0];
                FUNCT_SRAV: res = sraRef(opB, opA[4:0]);
                FUNCT_ADD:  sum = sa64 + sb64;
                FUNCT_SUB:  sum = sa64 - sb64;
                FUNCT_ADDU: res = opA + opB;
                FUNCT_SUBU: res = opA - opB;
                FUNCT_AND:  res = opA & opB;
                FUNCT_OR:   res = opA | opB;
                FUNCT_XOR:  res = opA ^ opB;
                FUNCT_NOR:  res = ~(opA | opB);
                FUNCT_SLT:  res = (sa64 < sb64) ? 32'd1 : 32'd0;
                FUNCT_SLTU: res = (opA < opB) ? 32'd1 : 32'd0;
                default:    rsv = 1'b1;
            endcase
            if (fn == FUNCT_ADD || fn == FUNCT_SUB)
                res = word_t'(sum);
        end
        else
        begin
            case (op)
                OP_ADDI:  sum = sa64 + sb64;
                OP_ADDIU: res = opA + se;
                OP_SLTI:  res = (sa64 < sb64) ? 32'd1 : 32'd0;
                OP_SLTIU: res = (opA < se) ? 32'd1 : 32'd0;
                OP_ANDI:  res = opA & ze;
                OP_ORI:   res = opA | ze;
                OP_XORI:  res = opA ^ ze;
                OP_LUI:   res = {ins[15:0], 16'h0000};
                default:  rsv = 1'b1;
            endcase
            if (op == OP_ADDI)
                res = word_t'(sum);
        end
        // Signed result outside the 32-bit range
        if (sum > 64'sd2147483647 || sum < -64'sd2147483648)
            ovf = 1'b1;
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Random register number fields that the DUT ignores
    function automatic instr_t rType(input logic [5:0] fn, input shamt_t amt);
        word_t fields;
        fields = $urandom;
        return {OP_SPECIAL, fields[14:0], amt, fn};
    endfunction

    function automatic instr_t iType(input logic [5:0] op, input logic [15:0] imm);
        word_t fields;
        fields = $urandom;
        return {op, fields[9:0], imm};
    endfunction

    // Load operands, run one instruction and check the commit
    task automatic runInstr(input instr_t ins, input word_t opA, input word_t opB,
                            input logic withStatus);
        word_t value;
        word_t got;
        logic  ovf;
        logic  rsv;
        if (opA !== shadowA)
        begin
            wbWrite(OPA_ADDR, opA);
            shadowA = opA;
        end
        if (opB !== shadowB)
        begin
            wbWrite(OPB_ADDR, opB);
            shadowB = opB;
        end
        wbWrite(INSTR_ADDR, ins);
        predictExec(ins, opA, opB, value, ovf, rsv);
        // Traps keep the old result and flag the cause
        expStatus = '0;
        if (rsv)
            expStatus[RESERVED_BIT] = 1'b1;
        else if (ovf)
            expStatus[OVERFLOW_BIT] = 1'b1;
        else
            expResult = value;
        wbRead(RESULT_ADDR, got);
        checkWord(got, expResult, $sformatf("result of %h", ins));
        if (withStatus)
        begin
            wbRead(STATUS_ADDR, got);
            checkStatus(got[RESERVED_BIT:0], expStatus, $sformatf("after %h", ins));
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic registerAccessTest();
        word_t    got;
        word_t    valA;
        word_t    valB;
        instr_t   ins;
        regAddr_t adr;
        int       i;
        // Whole map reads zero after reset
        for (i = 0; i < 8; i++)
        begin
            adr = regAddr_t'(i);
            wbRead(adr, got);
            checkAddr(adr, got, 32'h0);
        end
        valA = $urandom;
        valB = $urandom;
        wbWrite(OPA_ADDR, valA);
        wbWrite(OPB_ADDR, valB);
        shadowA = valA;
        shadowB = valB;
        wbRead(OPA_ADDR, got);
        checkAddr(OPA_ADDR, got, valA);
        wbRead(OPB_ADDR, got);
        checkAddr(OPB_ADDR, got, valB);
        // Instruction write evaluates and reads back
        ins = iType(OP_ORI, 16'h5A5A);
        runInstr(ins, shadowA, shadowB, 1'b1);
        wbRead(INSTR_ADDR, got);
        checkAddr(INSTR_ADDR, got, ins);
        // Read-only registers drop writes
        wbWrite(RESULT_ADDR, 32'hFFFF_FFFF);
        wbWrite(STATUS_ADDR, 32'hFFFF_FFFF);
        wbRead(RESULT_ADDR, got);
        checkAddr(RESULT_ADDR, got, expResult);
        wbRead(STATUS_ADDR, got);
        checkAddr(STATUS_ADDR, got, {30'h0, expStatus});
        // Unmapped space
        wbWrite(regAddr_t'(5), 32'hFFFF_FFFF);
        for (i = 5; i < 8; i++)
        begin
            adr = regAddr_t'(i);
            wbRead(adr, got);
            checkAddr(adr, got, 32'h0);
        end
    endtask

    task automatic rTypeTest();
        word_t      corner [4];
        logic [5:0] functs [10];
        word_t      pa;
        word_t      pb;
        int         p;
        int         f;
        corner = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
        functs = '{FUNCT_ADD, FUNCT_ADDU, FUNCT_SUB, FUNCT_SUBU, FUNCT_AND,
                   FUNCT_OR, FUNCT_XOR, FUNCT_NOR, FUNCT_SLT, FUNCT_SLTU};
        for (p = 0; p < 6; p++)
        begin
            // Neighbouring corners, then random pairs
            if (p < 4)
            begin
                pa = corner[p];
                pb = corner[(p + 1) % 4];
            end
            else
            begin
                pa = $urandom;
                pb = $urandom;
            end
            for (f = 0; f < 10; f++)
                runInstr(rType(functs[f], 5'd0), pa, pb, 1'b1);
        end
    endtask

    task automatic shiftTest();
        logic [5:0] fixedFns [3];
        logic [5:0] varFns [3];
        word_t      negB;
        word_t      valA;
        word_t      valB;
        int         sh;
        int         k;
        int         f;
        fixedFns = '{FUNCT_SLL, FUNCT_SRL, FUNCT_SRA};
        varFns   = '{FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV};
        negB     = $urandom;
        negB[31] = 1'b1;
        // Every sa value with the status read at the last one
        for (sh = 0; sh < 32; sh++)
        begin
            for (f = 0; f < 3; f++)
                runInstr(rType(fixedFns[f], shamt_t'(sh)), shadowA, negB, sh == 31);
        end
        for (k = 0; k < 4; k++)
        begin
            // Upper bits of A are noise
            valA     = $urandom;
            valB     = $urandom;
            valB[31] = (k % 2 == 0);
            for (f = 0; f < 3; f++)
                runInstr(rType(varFns[f], 5'd0), valA, valB, 1'b1);
        end
    endtask

    task automatic iTypeTest();
        logic [5:0]  ops [8];
        word_t       valA;
        word_t       rnd;
        logic [15:0] imm;
        int          k;
        int          o;
        ops = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        for (k = 0; k < 4; k++)
        begin
            valA    = $urandom;
            rnd     = $urandom;
            imm     = rnd[15:0];
            // Half of the immediates negative
            imm[15] = (k % 2 == 0);
            for (o = 0; o < 8; o++)
                runInstr(iType(ops[o], imm), valA, shadowB, 1'b1);
        end
        // 5 is below 0xFFFFFFFF unsigned but above -1 signed
        runInstr(iType(OP_SLTIU, 16'hFFFF), 32'h0000_0005, shadowB, 1'b1);
        runInstr(iType(OP_SLTI, 16'hFFFF), 32'h0000_0005, shadowB, 1'b1);
        // 0x10000 is below 0xFFFF8000 but not below a zero extended 0x8000
        runInstr(iType(OP_SLTIU, 16'h8000), 32'h0001_0000, shadowB, 1'b1);
    endtask

    task automatic trapTest();
        word_t got;
        // Known result to hold across traps
        runInstr(rType(FUNCT_ADDU, 5'd0), 32'd1, 32'd2, 1'b1);
        runInstr(rType(FUNCT_ADD, 5'd0), 32'h7FFF_FFFF, 32'd1, 1'b1);
        wbRead(RESULT_ADDR, got);
        checkWord(got, 32'd3, "result held over ADD overflow");
        runInstr(rType(FUNCT_ADDU, 5'd0), 32'h7FFF_FFFF, 32'd1, 1'b1);
        runInstr(rType(FUNCT_SUB, 5'd0), 32'h8000_0000, 32'd1, 1'b1);
        runInstr(rType(FUNCT_SUBU, 5'd0), 32'h8000_0000, 32'd1, 1'b1);
        runInstr(iType(OP_ADDI, 16'h0001), 32'h7FFF_FFFF, 32'd1, 1'b1);
        runInstr(iType(OP_ADDI, 16'hFFFF), 32'h8000_0000, 32'd1, 1'b1);
        runInstr(iType(OP_ADDIU, 16'hFFFF), 32'h8000_0000, 32'd1, 1'b1);
        // Overflow first, then reserved swaps the flags
        runInstr(rType(FUNCT_ADD, 5'd0), 32'h8000_0000, 32'h8000_0000, 1'b1);
        // MULT funct and LW opcode are outside the unit
        runInstr(rType(6'h18, 5'd0), 32'h8000_0000, 32'h8000_0000, 1'b1);
        runInstr(iType(6'h23, 16'h0010), 32'h8000_0000, 32'h8000_0000, 1'b1);
        // Valid instruction clears both flags
        runInstr(iType(OP_ORI, 16'h1234), 32'h0000_0001, 32'h8000_0000, 1'b1);
    endtask

    task automatic operandWriteTest();
        word_t got;
        word_t valA;
        word_t valB;
        valA = $urandom;
        valB = $urandom;
        wbWrite(OPA_ADDR, valA);
        wbWrite(OPB_ADDR, valB);
        shadowA = valA;
        shadowB = valB;
        wbRead(OPA_ADDR, got);
        checkAddr(OPA_ADDR, got, valA);
        wbRead(OPB_ADDR, got);
        checkAddr(OPB_ADDR, got, valB);
        // No evaluation from operand writes
        wbRead(RESULT_ADDR, got);
        checkWord(got, expResult, "result after operand writes");
        wbRead(STATUS_ADDR, got);
        checkStatus(got[RESERVED_BIT:0], expStatus, "after operand writes");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbAdr     = '0;
        wbDatW    = '0;
        expResult = '0;
        expStatus = '0;
        shadowA   = '0;
        shadowB   = '0;
        void'($urandom(32'h302e));
        // Hold off until reset releases
        @(posedge clk);
        while (reset)
            @(posedge clk);
        registerAccessTest();
        rTypeTest();
        shiftTest();
        iTypeTest();
        trapTest();
        operandWriteTest();
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* tb.f */
design/aluPkg.sv
design/aluCmdIf.sv
design/wbAluRegs.sv
design/mipsAluDecode.sv
design/mipsAlu.sv
design/aluTop.sv
verif/tbClockGen.sv
verif/aluTopTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the aluTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f tb.f --top-module aluTopTb \
    -Mdir obj_dir -o aluTopTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/aluTopTbSim)"
simStatus=$?
printf '%s\n' "$output"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
